//--- src/cpu_pkg.sv
package cpu_pkg;

  localparam int data_w = 32;
  localparam int addr_w = 5;
  localparam int mem_words = 64;
  localparam int pc_w = 6;
  localparam int count_w = 16;
  localparam int apb_addr_w = 12;

  typedef logic [data_w-1:0]  word_t;
  typedef logic [addr_w-1:0]  reg_addr_t;
  typedef logic [pc_w-1:0]    pc_t;
  typedef logic [5:0]         opcode_t;
  typedef logic [4:0]         sub_opcode_t;
  typedef logic [count_w-1:0] count_t;

  // major opcodes in instr[30:25]
  localparam opcode_t op_basic = 6'b100000;
  localparam opcode_t op_addi  = 6'b101000;
  localparam opcode_t op_ori   = 6'b101100;
  localparam opcode_t op_xori  = 6'b101011;
  localparam opcode_t op_movi  = 6'b100010;

  // basic sub-opcodes in instr[4:0]
  localparam sub_opcode_t sub_add   = 5'b00000;
  localparam sub_opcode_t sub_sub   = 5'b00001;
  localparam sub_opcode_t sub_and   = 5'b00010;
  localparam sub_opcode_t sub_or    = 5'b00100;
  localparam sub_opcode_t sub_xor   = 5'b00011;
  localparam sub_opcode_t sub_srli  = 5'b01001;
  localparam sub_opcode_t sub_slli  = 5'b01000;
  localparam sub_opcode_t sub_rotri = 5'b01011;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_srl, alu_sll, alu_rotr, alu_pass
  } alu_op_t;

  typedef enum logic [1:0] {imm5_ze, imm15_se, imm15_ze, imm20_se} imm_sel_t;
  typedef enum logic {wb_alu, wb_operand} wb_sel_t;
  typedef enum logic {opnd_reg, opnd_imm} operand_sel_t;

  typedef enum logic [1:0] {st_stop, st_fetch, st_exe, st_write} ctrl_state_t;

  typedef struct packed {
    alu_op_t      alu_op;
    imm_sel_t     imm_sel;
    operand_sel_t operand_sel;
    wb_sel_t      wb_sel;
    logic [19:0]  imm_field;
  } ctrl_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    word_t                 pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    word_t prdata;
    logic  pslverr;
  } apb_rsp_t;

  // byte address map
  localparam logic [apb_addr_w-1:0] imem_base = 12'h000;
  localparam logic [apb_addr_w-1:0] reg_base  = 12'h400;
  localparam logic [apb_addr_w-1:0] run_addr  = 12'h800;

endpackage

//--- src/ir_controller.sv
`timescale 1ns/10ps

module ir_controller (
  input  logic               clock,
  input  logic               reset,
  input  logic               start,
  input  cpu_pkg::count_t    run_count,
  input  cpu_pkg::word_t     ir,
  output cpu_pkg::pc_t       pc,
  output logic               busy,
  output cpu_pkg::count_t    remaining,
  output logic               enable_im_fetch,
  output logic               enable_reg_read,
  output logic               enable_alu_execute,
  output logic               enable_reg_write,
  output cpu_pkg::reg_addr_t read_address1,
  output cpu_pkg::reg_addr_t read_address2,
  output cpu_pkg::reg_addr_t write_address,
  output cpu_pkg::ctrl_t     ctrl
);
  import cpu_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;
  word_t       present_instruction;
  word_t       decode_word;
  opcode_t     opcode;
  sub_opcode_t sub_opcode;
  logic [4:0]  imm5;
  logic        is_nop;

  // in fetch the register addresses come straight from the memory output
  assign decode_word = (state == st_fetch) ? ir : present_instruction;

  assign opcode        = decode_word[30:25];
  assign sub_opcode    = decode_word[4:0];
  assign imm5          = decode_word[14:10];
  assign read_address1 = decode_word[19:15];
  assign read_address2 = decode_word[14:10];
  assign write_address = decode_word[24:20];

  assign busy = (remaining != '0);

  // srli r0 by zero
  assign is_nop = (opcode == op_basic) && (sub_opcode == sub_srli) &&
                  (imm5 == 5'd0) && (write_address == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_stop;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      st_stop: begin
        if (busy) begin
          next_state = st_fetch;
        end
      end
      st_fetch: next_state = st_exe;
      st_exe:   next_state = st_write;
      st_write: next_state = st_stop;
      default:  next_state = st_stop;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc                  <= '0;
      remaining           <= '0;
      present_instruction <= '0;
    end else begin
      if (state == st_fetch) begin
        present_instruction <= ir;
      end
      if (start && !busy) begin
        remaining <= run_count;
      end else if (state == st_write) begin
        remaining <= remaining - 1'b1;
        pc        <= pc + 1'b1;
      end
    end
  end

  assign enable_im_fetch    = (state == st_stop) && busy;
  assign enable_reg_read    = (state == st_fetch);
  assign enable_alu_execute = (state == st_exe);
  assign enable_reg_write   = (state == st_write) && !is_nop;

  always_comb begin
    ctrl.alu_op      = alu_add;
    ctrl.imm_sel     = imm5_ze;
    ctrl.operand_sel = opnd_reg;
    ctrl.wb_sel      = wb_alu;
    ctrl.imm_field   = decode_word[19:0];
    case (opcode)
      op_basic: begin
        case (sub_opcode)
          sub_sub: ctrl.alu_op = alu_sub;
          sub_and: ctrl.alu_op = alu_and;
          sub_or:  ctrl.alu_op = alu_or;
          sub_xor: ctrl.alu_op = alu_xor;
          sub_srli: begin
            ctrl.alu_op      = alu_srl;
            ctrl.operand_sel = opnd_imm;
          end
          sub_slli: begin
            ctrl.alu_op      = alu_sll;
            ctrl.operand_sel = opnd_imm;
          end
          sub_rotri: begin
            ctrl.alu_op      = alu_rotr;
            ctrl.operand_sel = opnd_imm;
          end
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_addi: begin
        ctrl.imm_sel     = imm15_se;
        ctrl.operand_sel = opnd_imm;
      end
      op_ori: begin
        ctrl.alu_op      = alu_or;
        ctrl.imm_sel     = imm15_ze;
        ctrl.operand_sel = opnd_imm;
      end
      op_xori: begin
        ctrl.alu_op      = alu_xor;
        ctrl.imm_sel     = imm15_ze;
        ctrl.operand_sel = opnd_imm;
      end
      op_movi: begin
        ctrl.alu_op      = alu_pass;
        ctrl.imm_sel     = imm20_se;
        ctrl.operand_sel = opnd_imm;
        ctrl.wb_sel      = wb_operand;
      end
      // load/store and unknown opcodes fall back to a register add
      default: ctrl.alu_op = alu_add;
    endcase
  end

endmodule

//--- src/instr_mem.sv
`timescale 1ns/10ps

module instr_mem (
  input  logic           clock,
  input  logic           imem_we,
  input  cpu_pkg::pc_t   imem_waddr,
  input  cpu_pkg::word_t imem_wdata,
  input  logic           enable_im_fetch,
  input  cpu_pkg::pc_t   pc,
  output cpu_pkg::word_t ir
);
  import cpu_pkg::*;

  word_t mem [mem_words];

  // program load port
  always_ff @(posedge clock) begin
    if (imem_we) begin
      mem[imem_waddr] <= imem_wdata;
    end
  end

  // ir holds until the next fetch
  always_ff @(posedge clock) begin
    if (enable_im_fetch) begin
      ir <= mem[pc];
    end
  end

endmodule

//--- src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic               clock,
  input  logic               reset,
  input  cpu_pkg::reg_addr_t read_address1,
  input  cpu_pkg::reg_addr_t read_address2,
  input  cpu_pkg::reg_addr_t write_address,
  input  logic               enable_reg_read,
  input  logic               enable_reg_write,
  input  cpu_pkg::word_t     result,
  input  cpu_pkg::reg_addr_t dbg_addr,
  output cpu_pkg::word_t     src1,
  output cpu_pkg::word_t     src2,
  output cpu_pkg::word_t     dbg_data
);
  import cpu_pkg::*;

  word_t regs [2**addr_w];

  // r0 is writable like any other register
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (enable_reg_write) begin
      regs[write_address] <= result;
    end
  end

  // operands latched during fetch
  always_ff @(posedge clock) begin
    if (enable_reg_read) begin
      src1 <= regs[read_address1];
      src2 <= regs[read_address2];
    end
  end

  assign dbg_data = regs[dbg_addr];

endmodule

//--- src/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
  input  logic           clock,
  input  logic           reset,
  input  cpu_pkg::ctrl_t ctrl,
  input  logic           enable_alu_execute,
  input  cpu_pkg::word_t src1,
  input  cpu_pkg::word_t src2,
  output cpu_pkg::word_t result
);
  import cpu_pkg::*;

  word_t imm_value;
  word_t operand_b;
  word_t alu_out;

  always_comb begin
    case (ctrl.imm_sel)
      imm5_ze:  imm_value = word_t'(ctrl.imm_field[14:10]);
      imm15_se: imm_value = {{(data_w-15){ctrl.imm_field[14]}}, ctrl.imm_field[14:0]};
      imm15_ze: imm_value = {{(data_w-15){1'b0}}, ctrl.imm_field[14:0]};
      imm20_se: imm_value = {{(data_w-20){ctrl.imm_field[19]}}, ctrl.imm_field};
      default:  imm_value = '0;
    endcase
  end

  assign operand_b = (ctrl.operand_sel == opnd_imm) ? imm_value : src2;

  always_comb begin
    logic [4:0]          shamt;
    logic [2*data_w-1:0] rot;
    shamt = operand_b[4:0];
    // rotate by shifting the doubled word
    rot = {src1, src1} >> shamt;
    case (ctrl.alu_op)
      alu_add:  alu_out = src1 + operand_b;
      alu_sub:  alu_out = src1 - operand_b;
      alu_and:  alu_out = src1 & operand_b;
      alu_or:   alu_out = src1 | operand_b;
      alu_xor:  alu_out = src1 ^ operand_b;
      alu_srl:  alu_out = src1 >> shamt;
      alu_sll:  alu_out = src1 << shamt;
      alu_rotr: alu_out = rot[data_w-1:0];
      alu_pass: alu_out = operand_b;
      default:  alu_out = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (enable_alu_execute) begin
      result <= (ctrl.wb_sel == wb_operand) ? operand_b : alu_out;
    end
  end

endmodule

//--- src/apb_slave.sv
`timescale 1ns/10ps

module apb_slave (
  input  logic               clock,
  input  logic               reset,
  input  cpu_pkg::apb_req_t  apb_req,
  input  logic               busy,
  input  cpu_pkg::count_t    remaining,
  input  cpu_pkg::word_t     dbg_data,
  output cpu_pkg::apb_rsp_t  apb_rsp,
  output logic               imem_we,
  output cpu_pkg::pc_t       imem_waddr,
  output cpu_pkg::word_t     imem_wdata,
  output logic               start,
  output cpu_pkg::count_t    run_count,
  output cpu_pkg::reg_addr_t dbg_addr
);
  import cpu_pkg::*;

  logic  setup;
  logic  access;
  logic  hit_imem;
  logic  hit_reg;
  logic  hit_run;
  logic  err_d;
  logic  err_q;
  word_t rdata_d;
  word_t rdata_q;

  assign setup  = apb_req.psel && !apb_req.penable;
  assign access = apb_req.psel && apb_req.penable;

  assign hit_imem = apb_req.paddr[apb_addr_w-1:pc_w+2] == imem_base[apb_addr_w-1:pc_w+2];
  assign hit_reg  = apb_req.paddr[apb_addr_w-1:addr_w+2] == reg_base[apb_addr_w-1:addr_w+2];
  assign hit_run  = apb_req.paddr == run_addr;

  assign dbg_addr = apb_req.paddr[addr_w+1:2];

  always_comb begin
    rdata_d = '0;
    if (hit_reg) begin
      rdata_d = dbg_data;
    end else if (hit_run) begin
      rdata_d = word_t'(remaining);
    end
  end

  // registers are read only and program memory is locked during a run
  assign err_d = !(hit_imem || hit_reg || hit_run) ||
                 (apb_req.pwrite && hit_reg) ||
                 (apb_req.pwrite && hit_imem && busy);

  // response decided in setup and presented in access
  always_ff @(posedge clock) begin
    if (reset) begin
      err_q <= 1'b0;
    end else if (setup) begin
      err_q <= err_d;
    end
  end

  always_ff @(posedge clock) begin
    if (setup) begin
      rdata_q <= rdata_d;
    end
  end

  assign imem_we    = access && apb_req.pwrite && hit_imem && !err_q;
  assign imem_waddr = apb_req.paddr[pc_w+1:2];
  assign imem_wdata = apb_req.pwdata;

  assign start     = access && apb_req.pwrite && hit_run && !err_q;
  assign run_count = apb_req.pwdata[count_w-1:0];

  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.prdata  = rdata_q;
  assign apb_rsp.pslverr = access && err_q;

endmodule

//--- src/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
  input  logic              clock,
  input  logic              reset,
  input  cpu_pkg::apb_req_t apb_req,
  output cpu_pkg::apb_rsp_t apb_rsp
);
  import cpu_pkg::*;

  logic      imem_we;
  pc_t       imem_waddr;
  word_t     imem_wdata;
  logic      start;
  count_t    run_count;
  count_t    remaining;
  logic      busy;
  reg_addr_t dbg_addr;
  word_t     dbg_data;

  pc_t       pc;
  word_t     ir;
  logic      enable_im_fetch;
  logic      enable_reg_read;
  logic      enable_alu_execute;
  logic      enable_reg_write;
  reg_addr_t read_address1;
  reg_addr_t read_address2;
  reg_addr_t write_address;
  ctrl_t     ctrl;
  word_t     src1;
  word_t     src2;
  word_t     result;

  apb_slave u_apb_slave (
    .clock(clock), .reset(reset), .apb_req(apb_req), .busy(busy),
    .remaining(remaining), .dbg_data(dbg_data), .apb_rsp(apb_rsp),
    .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
    .start(start), .run_count(run_count), .dbg_addr(dbg_addr)
  );

  ir_controller u_ir_controller (
    .clock(clock), .reset(reset), .start(start), .run_count(run_count),
    .ir(ir), .pc(pc), .busy(busy), .remaining(remaining),
    .enable_im_fetch(enable_im_fetch), .enable_reg_read(enable_reg_read),
    .enable_alu_execute(enable_alu_execute), .enable_reg_write(enable_reg_write),
    .read_address1(read_address1), .read_address2(read_address2),
    .write_address(write_address), .ctrl(ctrl)
  );

  instr_mem u_instr_mem (
    .clock(clock), .imem_we(imem_we), .imem_waddr(imem_waddr),
    .imem_wdata(imem_wdata), .enable_im_fetch(enable_im_fetch), .pc(pc), .ir(ir)
  );

  reg_file u_reg_file (
    .clock(clock), .reset(reset), .read_address1(read_address1),
    .read_address2(read_address2), .write_address(write_address),
    .enable_reg_read(enable_reg_read), .enable_reg_write(enable_reg_write),
    .result(result), .dbg_addr(dbg_addr), .src1(src1), .src2(src2),
    .dbg_data(dbg_data)
  );

  execute_unit u_execute_unit (
    .clock(clock), .reset(reset), .ctrl(ctrl),
    .enable_alu_execute(enable_alu_execute), .src1(src1), .src2(src2),
    .result(result)
  );

endmodule

//--- tests/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int half_period = 50;
  localparam int poll_limit = 500;

  typedef struct packed {
    logic [7:0] op;
    word_t      a;
    word_t      b;
    word_t      c;
  } command_t;

  logic     clock;
  logic     reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  command_t commands[$];
  string    names[$];
  int       errors;
  int       checks;

  cpu_top u_dut (
    .clock(clock),
    .reset(reset),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #half_period clock = ~clock;
    end
  end

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // setup then access phase with the response sampled on the closing rising edge
  task automatic apb_transfer(input logic write, input logic [11:0] addr,
                              input word_t wdata, output word_t rdata, output logic slverr);
    int waits;
    @(negedge clock);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clock);
    apb_req.penable = 1'b1;
    waits = 0;
    @(posedge clock);
    while (!apb_rsp.pready && waits < 16) begin
      waits++;
      @(posedge clock);
    end
    assert (apb_rsp.pready) else begin
      errors++;
      $display("no pready from the DUT for address %h", addr);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clock);
    apb_req = '0;
    repeat ($urandom % 2) @(negedge clock);
  endtask

  task automatic wait_idle();
    word_t count;
    logic  slverr;
    int    polls;
    polls = 0;
    apb_transfer(1'b0, run_addr, '0, count, slverr);
    while (count != '0 && polls < poll_limit) begin
      polls++;
      apb_transfer(1'b0, run_addr, '0, count, slverr);
    end
    assert (count == '0) else begin
      errors++;
      $display("core still busy after %0d polls of the run count", polls);
    end
  endtask

  task automatic read_commands(output int run_cycles);
    int       fd;
    int       n;
    int       fields;
    string    line;
    string    kind;
    string    name;
    command_t cmd;
    run_cycles = 0;
    fd = $fopen("tests/cpu_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open tests/cpu_input.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      cmd    = '0;
      name   = "";
      fields = 0;
      n = $sscanf(line, "%s", kind);
      if (n < 1 || kind == "#") begin
        continue;
      end
      if (kind == "L") begin
        n = $sscanf(line, "%s %h %h", kind, cmd.a, cmd.b);
        fields = 3;
        cmd.op = "L";
        name = $sformatf("load_%h", cmd.a[11:0]);
      end else if (kind == "R") begin
        n = $sscanf(line, "%s %d", kind, cmd.a);
        fields = 2;
        cmd.op = "R";
        name = $sformatf("run_%0d", cmd.a);
        run_cycles += 4 * int'(cmd.a) + 20;
      end else if (kind == "C") begin
        n = $sscanf(line, "%s %d %h %s", kind, cmd.a, cmd.b, name);
        fields = 4;
        cmd.op = "C";
      end else if (kind == "E") begin
        n = $sscanf(line, "%s %h %d %h %s", kind, cmd.a, cmd.b, cmd.c, name);
        fields = 5;
        cmd.op = "E";
      end else begin
        errors++;
        $display("unknown command %s in the input file", kind);
        continue;
      end
      if (n != fields) begin
        errors++;
        $display("incomplete %s command in the input file", kind);
        continue;
      end
      commands.push_back(cmd);
      names.push_back(name);
    end
    $fclose(fd);
  endtask

  task automatic check_reset_state();
    word_t rdata;
    logic  slverr;
    apb_transfer(1'b0, run_addr, '0, rdata, slverr);
    check_value("reset_run_count", '0, rdata);
    for (int r = 0; r < 32; r++) begin
      apb_transfer(1'b0, reg_base | {r[4:0], 2'b00}, '0, rdata, slverr);
      check_value($sformatf("reset_r%0d", r), '0, rdata);
    end
  endtask

  task automatic run_commands();
    word_t rdata;
    logic  slverr;
    foreach (commands[i]) begin
      case (commands[i].op)
        "L": begin
          apb_transfer(1'b1, commands[i].a[11:0], commands[i].b, rdata, slverr);
          check_value(names[i], '0, word_t'(slverr));
        end
        "R": begin
          wait_idle();
          apb_transfer(1'b1, run_addr, commands[i].a, rdata, slverr);
          check_value(names[i], '0, word_t'(slverr));
        end
        "C": begin
          wait_idle();
          apb_transfer(1'b0, reg_base | {commands[i].a[4:0], 2'b00}, '0, rdata, slverr);
          check_value(names[i], commands[i].b, rdata);
        end
        "E": begin
          apb_transfer(commands[i].b[0], commands[i].a[11:0], commands[i].c, rdata, slverr);
          check_value(names[i], 32'd1, word_t'(slverr));
        end
        default: begin
        end
      endcase
    end
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clock);
    $display("watchdog expired after %0d cycles before the tests finished", cycles);
    $display("Finished with errors");
    $finish;
  endtask

  initial begin
    int run_cycles;
    int budget;
    void'($urandom(95604));
    reset   = 1'b1;
    apb_req = '0;
    errors  = 0;
    checks  = 0;
    read_commands(run_cycles);
    // fixed allowance per apb command plus the reset read-back
    budget = 5 * run_cycles + 10 * (commands.size() + 40);
    fork
      watchdog(budget);
    join_none
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_reset_state();
    run_commands();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- compile.f
src/cpu_pkg.sv
src/ir_controller.sv
src/instr_mem.sv
src/reg_file.sv
src/execute_unit.sv
src/apb_slave.sv
src/cpu_top.sv
tests/cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module cpu_tb -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
  exit 1
fi
echo "simulation passed"

//--- tests/cpu_input.txt
# L addr data | R count | C reg value name | E addr write data name
# addr, data and value in hex, count and reg in decimal, E expects pslverr (write 1, read 0)
L 000 44112345
L 004 44280f0f
L 008 40308800
L 00c 40408801
L 010 40508802
L 014 40608804
L 018 40708803
L 01c 5080ffff
L 020 58a14000
L 024 56b17fff
L 028 40e11009
L 02c 40f0a008
L 030 4100900b
L 034 4111000b
L 038 40010009
R 15
C 2 fff80f0f movi_negative
C 3 fff93254 add
C 4 00091436 sub
C 5 00000305 and
C 6 fff92f4f or
C 7 fff92c4a xor
C 8 00012344 addi_negative
C 10 fff84f0f ori_zero_extend
C 11 fff870f0 xori_zero_extend
C 14 0fff80f0 srli
C 15 01234500 slli
C 16 50001234 rotri
C 17 fff80f0f rotri_zero
C 0 00000000 nop_no_write
L 03c 45400055
L 040 45500aaa
L 044 45600777
R 1
C 20 00000055 run_one
C 21 00000000 run_limit
R 2
E 044 1 45600111 imem_write_busy
C 21 00000aaa run_continue
C 22 00000777 imem_intact
E c00 1 00000000 unmapped_write
E 404 1 00000000 reg_write
